//--- bench/phyTxRefModel.svh
`ifndef PHYTX_REF_MODEL_SVH
`define PHYTX_REF_MODEL_SVH

// 5b/6b codes in abcdei order, RD- column, indexed by EDCBA.
localparam logic [5:0] refSixNeg [32] = '{
  6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes in fghj order, both columns, indexed by HGF.
localparam logic [3:0] refFourDataNeg [8] = '{4'b1011, 4'b1001, 4'b0101, 4'b1100,
                                              4'b1101, 4'b1010, 4'b0110, 4'b1110};
localparam logic [3:0] refFourDataPos [8] = '{4'b0100, 4'b1001, 4'b0101, 4'b0011,
                                              4'b0010, 4'b1010, 4'b0110, 4'b0001};
localparam logic [3:0] refFourCtlNeg [8]  = '{4'b1011, 4'b0110, 4'b1010, 4'b1100,
                                              4'b1101, 4'b0101, 4'b1001, 4'b0111};
localparam logic [3:0] refFourCtlPos [8]  = '{4'b0100, 4'b1001, 4'b0101, 4'b0011,
                                              4'b0010, 4'b1010, 4'b0110, 4'b1000};

logic refRdPos = 1'b0;  // Tracked running disparity, negative at start.

// Returns the symbol with bit 0 first on the line and advances the disparity.
function automatic logic [9:0] refEncode(input logic [7:0] b, input logic isK);
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] six;
  logic [3:0] four;
  logic       rdMid;
  logic [9:0] abcdeifghj;
  logic [9:0] lineOrder;
  x   = b[4:0];
  y   = b[7:5];
  six = (isK && x == 5'd28) ? 6'b001111 : refSixNeg[x];
  if (refRdPos && (($countones(six) != 3) || six == 6'b111000)) begin
    six = ~six;  // RD+ column is the complement.
  end
  rdMid = ($countones(six) > 3) ? 1'b1 : (($countones(six) < 3) ? 1'b0 : refRdPos);
  if (isK) begin
    four = rdMid ? refFourCtlPos[y] : refFourCtlNeg[y];
  end else if (y == 3'd7 && ((!rdMid && (x == 17 || x == 18 || x == 20)) ||
                             (rdMid && (x == 11 || x == 13 || x == 14)))) begin
    four = rdMid ? 4'b1000 : 4'b0111;  // Alternate D.x.A7 form.
  end else begin
    four = rdMid ? refFourDataPos[y] : refFourDataNeg[y];
  end
  abcdeifghj = {six, four};
  for (int i = 0; i < 10; i++) begin
    lineOrder[i] = abcdeifghj[9 - i];
  end
  if ($countones(abcdeifghj) > 5) begin
    refRdPos = 1'b1;
  end else if ($countones(abcdeifghj) < 5) begin
    refRdPos = 1'b0;
  end
  return lineOrder;
endfunction

`endif

//--- bench/phyTxTb.sv
`timescale 1ns/1ps
`default_nettype none

module phyTxTb;

  import phyTxPkg::*;

  `include "phyTxRefModel.svh"

  localparam int tickCycles = 10;   // PCLK cycles per symbol slot.
  localparam int waitLimit  = 60;
  localparam int drainLimit = 100;

  typedef struct packed {
    busWidthT    width;
    logic [31:0] word;
    logic [3:0]  k;
    logic        en;
  } stimT;

  logic        PCLK;
  logic        Reset_n;
  busWidthT    dataBusWidth;
  logic [31:0] macTxData;
  logic [3:0]  macTxDataK;
  logic        macDataEn;
  wire         txOutP;
  wire         txOutN;
  wire         wordTaken;

  integer      seed;
  stimT        stim [$];
  logic [10:0] expQ [$];            // Valid flag over the 10-bit symbol.
  int          pushedCount = 0;
  int          checkedCount = 0;
  int          failCount = 0;
  logic        lineStarted = 1'b0;
  int          lineCycle;
  logic        slotActive = 1'b0;
  logic [10:0] slotExp;
  logic [9:0]  slotGot;

  phyTx UUT (
    .PCLK         (PCLK),
    .Reset_n      (Reset_n),
    .dataBusWidth (dataBusWidth),
    .macTxData    (macTxData),
    .macTxDataK   (macTxDataK),
    .macDataEn    (macDataEn),
    .txOutP       (txOutP),
    .txOutN       (txOutN),
    .wordTaken    (wordTaken)
  );

  initial begin
    PCLK = 1'b0;
    forever #10 PCLK = ~PCLK;
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      failCount++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic timedOut(input string what);
    $display("Timeout while waiting for %s.", what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopped on a timeout.");
  endtask

  // A word with rnd set gets random data in place of the given word.
  task automatic addEntry(input busWidthT w, input logic [31:0] word, input logic [3:0] k,
                          input logic en, input logic rnd);
    stimT e;
    e.width = w;
    e.word  = rnd ? $random(seed) : word;
    e.k     = k;
    e.en    = en;
    stim.push_back(e);
  endtask

  function automatic int laneCount(input busWidthT w);
    case (w)
      width16: return 2;
      width32: return 4;
      default: return 1;
    endcase
  endfunction

  task automatic applyEntry(input stimT e);
    dataBusWidth <= e.width;
    macTxData    <= e.word;
    macTxDataK   <= e.k;
    macDataEn    <= e.en;
  endtask

  // Idle lanes leave the tracked disparity alone.
  task automatic pushExpected(input stimT e);
    for (int lane = 0; lane < laneCount(e.width); lane++) begin
      if (e.en) begin
        expQ.push_back({1'b1, refEncode(e.word[lane * 8 +: 8], e.k[lane])});
      end else begin
        expQ.push_back(11'h000);
      end
      pushedCount++;
    end
  endtask

  task automatic waitWordTaken(input logic lineQuiet, output int cycles);
    cycles = 0;
    do begin
      @(negedge PCLK);
      cycles++;
      if (lineQuiet) begin
        checkValue("txOutP", txOutP, 1'b0);
        checkValue("txOutN", txOutN, 1'b0);
      end
      if (cycles > waitLimit) begin
        timedOut("wordTaken");
      end
    end while (!wordTaken);
  endtask

  task automatic sampleBit(input int bitIdx);
    if (bitIdx == 0) begin
      slotActive = (expQ.size() > 0);
      if (slotActive) begin
        slotExp = expQ.pop_front();
      end
    end
    if (slotActive) begin
      if (slotExp[10]) begin
        slotGot[bitIdx] = txOutP;
        checkValue("txOutN", txOutN, !slotExp[bitIdx]);   // Complement of the sent bit.
      end else begin
        checkValue("txOutP", txOutP, 1'b0);
        checkValue("txOutN", txOutN, 1'b0);
      end
      if (bitIdx == 9) begin
        if (slotExp[10]) begin
          checkValue("symbol", slotGot, slotExp[9:0]);
        end
        checkedCount++;
      end
    end
  endtask

  // Lane 0 of a word reaches the line 3 cycles after its capturing tick.
  initial begin
    forever begin
      @(negedge PCLK);
      if (lineStarted) begin
        lineCycle++;
        if (lineCycle >= 3) begin
          sampleBit((lineCycle - 3) % tickCycles);
        end
      end else if (wordTaken) begin
        lineStarted = 1'b1;
        lineCycle   = 0;
      end
    end
  end

  initial begin
    int cycles;
    int waited;
    Reset_n      = 1'b0;
    dataBusWidth = width8;
    macTxData    = 32'h0;
    macTxDataK   = 4'h0;
    macDataEn    = 1'b0;
    seed         = 32'h1dc1;

    addEntry(width32, 32'h0,        4'b0000, 1'b1, 1'b1);
    addEntry(width32, 32'h0,        4'b0000, 1'b1, 1'b1);
    addEntry(width32, 32'h4ABC1CBC, 4'b0111, 1'b1, 1'b0);  // K28.5, K28.0, K28.5, data.
    addEntry(width32, 32'hFE55F7BC, 4'b1011, 1'b1, 1'b0);  // K28.5, K23.7, data, K30.7.
    addEntry(width32, 32'hBCBCBCBC, 4'b1111, 1'b1, 1'b0);
    addEntry(width32, 32'hEBF1EBF1, 4'b0000, 1'b1, 1'b0);  // D.17.7 and D.11.7 for A7.
    addEntry(width32, 32'h0,        4'b0000, 1'b0, 1'b1);
    addEntry(width32, 32'h0,        4'b0000, 1'b1, 1'b1);
    addEntry(width8,  32'h0,        4'b0000, 1'b1, 1'b1);
    addEntry(width8,  32'h000000BC, 4'b0001, 1'b1, 1'b0);
    addEntry(width8,  32'h0,        4'b0000, 1'b0, 1'b1);
    addEntry(width16, 32'h0,        4'b0000, 1'b1, 1'b1);
    addEntry(width16, 32'h0000F71C, 4'b0011, 1'b1, 1'b0);
    addEntry(width16, 32'h0,        4'b0000, 1'b0, 1'b1);
    addEntry(width32, 32'h0,        4'b0000, 1'b1, 1'b1);

    for (int i = 0; i < 16; i++) begin
      @(negedge PCLK);
      checkValue("txOutP", txOutP, 1'b0);
      checkValue("txOutN", txOutN, 1'b0);
      checkValue("wordTaken", wordTaken, 1'b0);
    end
    @(posedge PCLK);
    Reset_n <= 1'b1;
    applyEntry(stim[0]);

    for (int i = 0; i < stim.size(); i++) begin
      if (i == 0) begin
        waitWordTaken(1'b1, cycles);
        checkValue("first wordTaken cycle", cycles, tickCycles);
      end else begin
        waitWordTaken(1'b0, cycles);
        checkValue("wordTaken spacing", cycles, tickCycles * laneCount(stim[i - 1].width));
      end
      pushExpected(stim[i]);
      @(posedge PCLK);                                      // This edge captures the word.
      if (i + 1 < stim.size()) begin
        applyEntry(stim[i + 1]);
      end else begin
        macDataEn <= 1'b0;
      end
    end

    waited = 0;
    while (checkedCount < pushedCount) begin
      @(negedge PCLK);
      waited++;
      if (waited > drainLimit) begin
        timedOut("the last symbols on the line");
      end
    end

    if (failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
+incdir+bench
verilog/phyTxPkg.sv
verilog/txWordLatch.sv
verilog/encoder8b10b.sv
verilog/txSerializer.sv
verilog/phyTx.sv
bench/phyTxTb.sv

//--- verilog/encoder8b10b.sv
`timescale 1ns/1ps
`default_nettype none

`include "phyTx_config.svh"

module encoder8b10b (
  input  wire                PCLK,
  input  wire                Reset_n,
  input  wire phyTxPkg::symbolT sym,
  input  wire                symStrobe,
  output phyTxPkg::codeT     code,
  output logic               codeStrobe
);

  import phyTxPkg::*;

  logic [4:0]              x;         // EDCBA.
  logic [2:0]              y;         // HGF.
  logic                    rdPos;     // Running disparity, high when positive.
  logic                    isK28;
  logic [5:0]              sixRaw;
  logic                    flip6;
  logic [5:0]              six;       // abcdei with a as the MSB.
  logic                    rdMid;
  logic                    useA7;
  logic [3:0]              fourRaw;
  logic                    flip4;
  logic [3:0]              four;      // fghj with f as the MSB.
  logic                    rdOut;
  logic [`SYMBOL_BITS-1:0] encoded;
  codeT                    nextCode;

  // 5b/6b table, RD- column.
  function automatic logic [5:0] enc6(input logic [4:0] v);
    case (v)
      5'd0:    enc6 = 6'b100111;
      5'd1:    enc6 = 6'b011101;
      5'd2:    enc6 = 6'b101101;
      5'd3:    enc6 = 6'b110001;
      5'd4:    enc6 = 6'b110101;
      5'd5:    enc6 = 6'b101001;
      5'd6:    enc6 = 6'b011001;
      5'd7:    enc6 = 6'b111000;
      5'd8:    enc6 = 6'b111001;
      5'd9:    enc6 = 6'b100101;
      5'd10:   enc6 = 6'b010101;
      5'd11:   enc6 = 6'b110100;
      5'd12:   enc6 = 6'b001101;
      5'd13:   enc6 = 6'b101100;
      5'd14:   enc6 = 6'b011100;
      5'd15:   enc6 = 6'b010111;
      5'd16:   enc6 = 6'b011011;
      5'd17:   enc6 = 6'b100011;
      5'd18:   enc6 = 6'b010011;
      5'd19:   enc6 = 6'b110010;
      5'd20:   enc6 = 6'b001011;
      5'd21:   enc6 = 6'b101010;
      5'd22:   enc6 = 6'b011010;
      5'd23:   enc6 = 6'b111010;
      5'd24:   enc6 = 6'b110011;
      5'd25:   enc6 = 6'b100110;
      5'd26:   enc6 = 6'b010110;
      5'd27:   enc6 = 6'b110110;
      5'd28:   enc6 = 6'b001110;
      5'd29:   enc6 = 6'b101110;
      5'd30:   enc6 = 6'b011110;
      default: enc6 = 6'b101011;
    endcase
  endfunction

  // 3b/4b data table, RD- column, primary form for y = 7.
  function automatic logic [3:0] enc4(input logic [2:0] v);
    case (v)
      3'd0:    enc4 = 4'b1011;
      3'd1:    enc4 = 4'b1001;
      3'd2:    enc4 = 4'b0101;
      3'd3:    enc4 = 4'b1100;
      3'd4:    enc4 = 4'b1101;
      3'd5:    enc4 = 4'b1010;
      3'd6:    enc4 = 4'b0110;
      default: enc4 = 4'b1110;
    endcase
  endfunction

  // Control sub-blocks, RD- column; every entry flips at RD+.
  function automatic logic [3:0] enc4K(input logic [2:0] v);
    case (v)
      3'd0:    enc4K = 4'b1011;
      3'd1:    enc4K = 4'b0110;
      3'd2:    enc4K = 4'b1010;
      3'd3:    enc4K = 4'b1100;
      3'd4:    enc4K = 4'b1101;
      3'd5:    enc4K = 4'b0101;
      3'd6:    enc4K = 4'b1001;
      default: enc4K = 4'b0111;
    endcase
  endfunction

  assign x     = sym.data[4:0];
  assign y     = sym.data[7:5];
  assign isK28 = sym.isK && (x == 5'd28);
  assign useA7 = (y == 3'd7) &&
                 ((!rdMid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                  (rdMid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

  always_comb begin
    sixRaw = isK28 ? 6'b001111 : enc6(x);
    flip6  = ($countones(sixRaw) != 3) || ((x == 5'd7) && !sym.isK);  // D.07 is balanced but flips.
    six    = (rdPos && flip6) ? ~sixRaw : sixRaw;
    rdMid  = ($countones(six) != 3) ? ~rdPos : rdPos;

    if (sym.isK) begin
      fourRaw = enc4K(y);
      flip4   = 1'b1;
    end else if (useA7) begin
      fourRaw = 4'b0111;                                     // Avoids a run of five.
      flip4   = 1'b1;
    end else begin
      fourRaw = enc4(y);
      flip4   = ($countones(fourRaw) != 2) || (y == 3'd3);
    end
    four  = (rdMid && flip4) ? ~fourRaw : fourRaw;
    rdOut = ($countones(four) != 2) ? ~rdMid : rdMid;

    for (int i = 0; i < 6; i++) begin
      encoded[i] = six[5 - i];                               // Bit a is sent first.
    end
    for (int i = 0; i < 4; i++) begin
      encoded[6 + i] = four[3 - i];
    end

    nextCode.code  = sym.valid ? encoded : {2'b00, sym.data};
    nextCode.valid = sym.valid;
  end

  always_ff @(posedge PCLK or negedge Reset_n) begin
    if (!Reset_n) begin
      rdPos      <= 1'b0;                                    // Start at RD-.
      codeStrobe <= 1'b0;
    end else begin
      codeStrobe <= symStrobe;
      if (symStrobe && sym.valid) begin
        rdPos <= rdOut;                                      // Idle lanes keep the disparity.
      end
    end
  end

  always_ff @(posedge PCLK) begin
    if (symStrobe) begin
      code <= nextCode;
    end
  end

endmodule

`default_nettype wire

//--- verilog/phyTx.sv
`timescale 1ns/1ps
`default_nettype none

module phyTx (
  input  wire                      PCLK,
  input  wire                      Reset_n,
  input  wire phyTxPkg::busWidthT  dataBusWidth,
  input  wire [31:0]               macTxData,
  input  wire [3:0]                macTxDataK,
  input  wire                      macDataEn,
  output wire                      txOutP,
  output wire                      txOutN,
  output wire                      wordTaken
);

  import phyTxPkg::*;

  wire symbolT sym;          // Byte lane from the latch.
  wire         symStrobe;
  wire codeT   code;         // Encoded symbol for the line.
  wire         codeStrobe;

  txWordLatch wordLatchU (
    .PCLK         (PCLK),
    .Reset_n      (Reset_n),
    .dataBusWidth (dataBusWidth),
    .macTxData    (macTxData),
    .macTxDataK   (macTxDataK),
    .macDataEn    (macDataEn),
    .wordTaken    (wordTaken),
    .sym          (sym),
    .symStrobe    (symStrobe)
  );

  encoder8b10b encoderU (
    .PCLK       (PCLK),
    .Reset_n    (Reset_n),
    .sym        (sym),
    .symStrobe  (symStrobe),
    .code       (code),
    .codeStrobe (codeStrobe)
  );

  // The pair is driven straight from the serializer registers.
  txSerializer serializerU (
    .PCLK       (PCLK),
    .Reset_n    (Reset_n),
    .code       (code),
    .codeStrobe (codeStrobe),
    .txOutP     (txOutP),
    .txOutN     (txOutN)
  );

endmodule

`default_nettype wire

//--- verilog/phyTxPkg.sv
`default_nettype none

`include "phyTx_config.svh"

package phyTxPkg;

  // Bus width code, which sets the byte lanes per MAC word.
  typedef enum logic [1:0] {
    width8  = 2'd0,  // One lane per word.
    width16 = 2'd1,  // Two lanes per word.
    width32 = 2'd2   // Four lanes per word.
  } busWidthT;

  // One byte lane on its way to the encoder.
  typedef struct packed {
    logic [7:0] data;   // Byte HGFEDCBA, A is bit 0.
    logic       isK;    // Control character flag.
    logic       valid;  // Low for an idle lane.
  } symbolT;

  // One 10-bit symbol on its way to the serializer.
  typedef struct packed {
    logic [`SYMBOL_BITS-1:0] code;   // Bit 0 goes out first.
    logic                    valid;  // Low means electrical idle.
  } codeT;

endpackage

`default_nettype wire

//--- verilog/phyTx_config.svh
`ifndef PHYTX_CONFIG_SVH
`define PHYTX_CONFIG_SVH

// Bits in one encoded 8b/10b symbol.
`define SYMBOL_BITS 10

// PCLK is the bit clock, so one symbol slot lasts this many cycles.
// It has to match SYMBOL_BITS for the line to stay gapless.
`define TICK_PERIOD 10

`endif

//--- verilog/txSerializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "phyTx_config.svh"

module txSerializer (
  input  wire                  PCLK,
  input  wire                  Reset_n,
  input  wire phyTxPkg::codeT  code,
  input  wire                  codeStrobe,
  output logic                 txOutP,
  output logic                 txOutN
);

  localparam int cntWidth = $clog2(`SYMBOL_BITS + 1);

  logic [`SYMBOL_BITS-1:0] shiftReg;
  logic [cntWidth-1:0]     bitsLeft;    // Bits still to go after the one on the line.
  logic                    lineValid;

  always_ff @(posedge PCLK or negedge Reset_n) begin
    if (!Reset_n) begin
      txOutP    <= 1'b0;
      txOutN    <= 1'b0;
      lineValid <= 1'b0;
      bitsLeft  <= '0;
    end else if (codeStrobe) begin
      txOutP    <= code.valid & code.code[0];                // First bit goes out right away.
      txOutN    <= code.valid & ~code.code[0];
      lineValid <= code.valid;
      bitsLeft  <= cntWidth'(`SYMBOL_BITS - 1);
    end else if (bitsLeft != '0) begin
      txOutP   <= lineValid & shiftReg[0];
      txOutN   <= lineValid & ~shiftReg[0];                  // Both stay low while idle.
      bitsLeft <= bitsLeft - cntWidth'(1);
    end else begin
      // Nothing new was loaded, so the pair drops to electrical idle.
      txOutP    <= 1'b0;
      txOutN    <= 1'b0;
      lineValid <= 1'b0;
    end
  end

  always_ff @(posedge PCLK) begin
    if (codeStrobe) begin
      shiftReg <= code.code >> 1;                            // Bit 0 is already on the line.
    end else begin
      shiftReg <= shiftReg >> 1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/txWordLatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "phyTx_config.svh"

module txWordLatch (
  input  wire                       PCLK,
  input  wire                       Reset_n,
  input  wire phyTxPkg::busWidthT   dataBusWidth,
  input  wire [31:0]                macTxData,
  input  wire [3:0]                 macTxDataK,
  input  wire                       macDataEn,
  output logic                      wordTaken,
  output phyTxPkg::symbolT          sym,
  output logic                      symStrobe
);

  import phyTxPkg::*;

  localparam int cntWidth = $clog2(`TICK_PERIOD);

  logic [cntWidth-1:0] tickCnt;
  logic                tick;
  logic [1:0]          laneIdx;
  logic [1:0]          lastLane;
  logic                firstLane;
  busWidthT            curWidth;
  busWidthT            effWidth;
  logic [31:0]         wordReg;
  logic [3:0]          kReg;
  logic                enReg;
  logic [7:0]          laneData;
  logic                laneK;
  logic                laneEn;

  assign tick      = (tickCnt == cntWidth'(`TICK_PERIOD - 1));
  assign firstLane = (laneIdx == 2'd0);
  assign wordTaken = tick & firstLane;                       // The MAC may move on after this.
  assign effWidth  = firstLane ? dataBusWidth : curWidth;    // New width only at a word start.

  always_comb begin
    case (effWidth)
      width16: lastLane = 2'd1;
      width32: lastLane = 2'd3;
      default: lastLane = 2'd0;
    endcase
  end

  // Lane 0 comes straight off the MAC bus, later lanes from the captured word.
  always_comb begin
    if (firstLane) begin
      laneData = macTxData[7:0];
      laneK    = macTxDataK[0];
      laneEn   = macDataEn;
    end else begin
      laneData = wordReg[{laneIdx, 3'b000} +: 8];
      laneK    = kReg[laneIdx];
      laneEn   = enReg;
    end
  end

  always_ff @(posedge PCLK or negedge Reset_n) begin
    if (!Reset_n) begin
      tickCnt   <= '0;
      laneIdx   <= 2'd0;
      curWidth  <= width8;
      enReg     <= 1'b0;
      symStrobe <= 1'b0;
    end else begin
      symStrobe <= tick;                                     // Symbol is registered on the tick.
      if (tick) begin
        tickCnt <= '0;
        laneIdx <= (laneIdx == lastLane) ? 2'd0 : laneIdx + 2'd1;
        if (firstLane) begin
          curWidth <= dataBusWidth;
          enReg    <= macDataEn;
        end
      end else begin
        tickCnt <= tickCnt + cntWidth'(1);
      end
    end
  end

  always_ff @(posedge PCLK) begin
    if (tick) begin
      sym.data  <= laneData;
      sym.isK   <= laneK;
      sym.valid <= laneEn;
      if (firstLane) begin
        wordReg <= macTxData;
        kReg    <= macTxDataK;
      end
    end
  end

endmodule

`default_nettype wire
